//--- all.f
+incdir+common
common/isa_pkg.sv
common/ctrl_pkg.sv
decode/mainDecoder.sv
src/aluUnit.sv
src/writebackStage.sv
mdu/mduTimer.sv
mdu/mduUnit.sv
src/issueFsm.sv
src/instrFifo.sv
src/execTop.sv
bench/execTb.sv

//--- run.sh
#!/bin/sh
# Build the execTop testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module execTb -o execSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/execSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
	exit 0
fi
exit 1

//--- bench/execTb.sv
`include "exec_config.svh"

module execTb;
	import isa_pkg::*;
	import ctrl_pkg::*;

	typedef logic [$clog2(`EXEC_FIFO_DEPTH):0] creditCount;

	logic     clk;
	logic     arstN;
	logic     issueValid;
	issuePkt  issue;
	logic     creditReturn;
	retirePkt retire;
	logic     retireValid;

	// Stimulus table and expected retire packets, in issue order
	issuePkt  stimPkt [$];
	retirePkt expPkt [$];
	bit       expValChk [$];
	string    caseName [$];

	logic [31:0] lcgState;
	creditCount  credits;
	creditCount  minCredits;
	int          nIssued;
	int          nRetired;
	int          returned;
	int          cycles;
	int          limit;
	int          nChecks;
	int          errors;
	bit          timedOut;

	execTop i_dut (
		.clk, .arstN, .issueValid, .issue,
		.creditReturn, .retire, .retireValid
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// SPECIAL encoding with rs=1, rt=2
	function automatic instrWord rType(functField fn, regIdx rd, logic [4:0] sa);
		return {6'h00, 5'd1, 5'd2, rd, sa, fn};
	endfunction

	function automatic instrWord iType(opcodeField op, regIdx rt, logic [15:0] imm);
		return {op, 5'd1, rt, imm};
	endfunction

	task automatic addCase(string name, instrWord instr, dataWord rsV, dataWord rtV,
		regIdx dest, dataWord value, logic we, bit chkVal);
		issuePkt  p;
		retirePkt e;
		p.instr = instr;
		p.rsVal = rsV;
		p.rtVal = rtV;
		e.dest  = dest;
		e.value = value;
		e.regWe = we;
		stimPkt.push_back(p);
		expPkt.push_back(e);
		expValChk.push_back(chkVal);
		caseName.push_back(name);
	endtask

	//////////////////////////////////////////////////
	// Directed table
	//////////////////////////////////////////////////
	task automatic buildTable();
		// Divide first so the queue fills and credits run out
		addCase("divu", rType(fnDivu, 5'd0, 5'd0), 32'd100, 32'd7, 5'd0, 32'd0, 1'b0, 1'b0);
		addCase("mflo divu", rType(fnMflo, 5'd2, 5'd0), 0, 0, 5'd2, 32'd14, 1'b1, 1'b1);
		addCase("mfhi divu", rType(fnMfhi, 5'd3, 5'd0), 0, 0, 5'd3, 32'd2, 1'b1, 1'b1);
		addCase("mult", rType(fnMult, 5'd0, 5'd0), 32'hFFFFFFFD, 32'd5, 5'd0, 0, 1'b0, 1'b0);
		addCase("mfhi mult", rType(fnMfhi, 5'd4, 5'd0), 0, 0, 5'd4, 32'hFFFFFFFF, 1'b1, 1'b1);
		addCase("mflo mult", rType(fnMflo, 5'd5, 5'd0), 0, 0, 5'd5, 32'hFFFFFFF1, 1'b1, 1'b1);
		addCase("multu", rType(fnMultu, 5'd0, 5'd0), 32'hFFFFFFFF, 32'd2, 5'd0, 0, 1'b0, 1'b0);
		addCase("mfhi multu", rType(fnMfhi, 5'd6, 5'd0), 0, 0, 5'd6, 32'd1, 1'b1, 1'b1);
		addCase("mflo multu", rType(fnMflo, 5'd7, 5'd0), 0, 0, 5'd7, 32'hFFFFFFFE, 1'b1, 1'b1);
		addCase("div", rType(fnDiv, 5'd0, 5'd0), 32'hFFFFFFF9, 32'd2, 5'd0, 0, 1'b0, 1'b0);
		addCase("mflo div", rType(fnMflo, 5'd8, 5'd0), 0, 0, 5'd8, 32'hFFFFFFFD, 1'b1, 1'b1);
		addCase("mfhi div", rType(fnMfhi, 5'd9, 5'd0), 0, 0, 5'd9, 32'hFFFFFFFF, 1'b1, 1'b1);
		addCase("div by 0", rType(fnDiv, 5'd0, 5'd0), 32'h1234, 32'd0, 5'd0, 0, 1'b0, 1'b0);
		addCase("mflo div0", rType(fnMflo, 5'd8, 5'd0), 0, 0, 5'd8, 32'hFFFFFFFF, 1'b1, 1'b1);
		addCase("mfhi div0", rType(fnMfhi, 5'd9, 5'd0), 0, 0, 5'd9, 32'h1234, 1'b1, 1'b1);
		addCase("mthi", rType(fnMthi, 5'd0, 5'd0), 32'hCAFEF00D, 0, 5'd0, 0, 1'b0, 1'b0);
		addCase("mfhi mthi", rType(fnMfhi, 5'd10, 5'd0), 0, 0, 5'd10, 32'hCAFEF00D, 1'b1, 1'b1);
		addCase("mtlo", rType(fnMtlo, 5'd0, 5'd0), 32'h0BADBEEF, 0, 5'd0, 0, 1'b0, 1'b0);
		addCase("mflo mtlo", rType(fnMflo, 5'd11, 5'd0), 0, 0, 5'd11, 32'h0BADBEEF, 1'b1, 1'b1);
		// R-type ALU, result to rd
		addCase("add", rType(fnAdd, 5'd12, 5'd0), 32'd3, 32'd4, 5'd12, 32'd7, 1'b1, 1'b1);
		addCase("subu", rType(fnSubu, 5'd13, 5'd0), 32'd5, 32'd7, 5'd13, 32'hFFFFFFFE, 1'b1, 1'b1);
		addCase("and", rType(fnAnd, 5'd14, 5'd0), 32'hF0F0, 32'hFF00, 5'd14, 32'hF000, 1'b1, 1'b1);
		addCase("or", rType(fnOr, 5'd15, 5'd0), 32'hF0F0, 32'h0F00, 5'd15, 32'hFFF0, 1'b1, 1'b1);
		addCase("nor", rType(fnNor, 5'd16, 5'd0), 32'd0, 32'd0, 5'd16, 32'hFFFFFFFF, 1'b1, 1'b1);
		addCase("slt", rType(fnSlt, 5'd17, 5'd0), 32'hFFFFFFFF, 32'd1, 5'd17, 32'd1, 1'b1, 1'b1);
		addCase("sltu", rType(fnSltu, 5'd18, 5'd0), 32'hFFFFFFFF, 32'd1, 5'd18, 0, 1'b1, 1'b1);
		addCase("sll", rType(fnSll, 5'd19, 5'd4), 0, 32'd1, 5'd19, 32'h10, 1'b1, 1'b1);
		addCase("srl", rType(fnSrl, 5'd20, 5'd31), 0, 32'h80000000, 5'd20, 32'd1, 1'b1, 1'b1);
		addCase("sra", rType(fnSra, 5'd21, 5'd4), 0, 32'h80000000, 5'd21, 32'hF8000000, 1'b1, 1'b1);
		addCase("sllv", rType(fnSllv, 5'd22, 5'd0), 32'd3, 32'd1, 5'd22, 32'd8, 1'b1, 1'b1);
		addCase("srlv", rType(fnSrlv, 5'd23, 5'd0), 32'd36, 32'h100, 5'd23, 32'h10, 1'b1, 1'b1);
		addCase("srav", rType(fnSrav, 5'd24, 5'd0), 32'd1, 32'hFFFFFFFE, 5'd24, '1, 1'b1, 1'b1);
		// Immediate forms write rt
		addCase("addiu", iType(opAddiu, 5'd25, 16'hFFFF), 32'd10, 0, 5'd25, 32'd9, 1'b1, 1'b1);
		addCase("andi", iType(opAndi, 5'd26, 16'h8001), '1, 0, 5'd26, 32'h8001, 1'b1, 1'b1);
		addCase("ori", iType(opOri, 5'd27, 16'h0001), 32'h10000, 0, 5'd27, 32'h10001, 1'b1, 1'b1);
		addCase("xori", iType(opXori, 5'd28, 16'h00FF), 32'hF, 0, 5'd28, 32'hF0, 1'b1, 1'b1);
		addCase("slti", iType(opSlti, 5'd29, 16'hFFFF), 32'd5, 0, 5'd29, 32'd0, 1'b1, 1'b1);
		addCase("sltiu", iType(opSltiu, 5'd30, 16'hFFFF), 32'd5, 0, 5'd30, 32'd1, 1'b1, 1'b1);
		addCase("lui", iType(opLui, 5'd1, 16'h1234), 0, 0, 5'd1, 32'h12340000, 1'b1, 1'b1);
		// Control flow, stores and unknown encodings never write
		addCase("beq", iType(opBeq, 5'd2, 16'h0004), 0, 0, 5'd0, 0, 1'b0, 1'b0);
		addCase("sw", iType(opSw, 5'd3, 16'h0010), 0, 0, 5'd0, 0, 1'b0, 1'b0);
		addCase("j", iType(opJ, 5'd0, 16'h0100), 0, 0, 5'd0, 0, 1'b0, 1'b0);
		addCase("jr", rType(fnJr, 5'd0, 5'd0), 0, 0, 5'd0, 0, 1'b0, 1'b0);
		addCase("unknown", iType(6'h3f, 5'd4, 16'h0000), 0, 0, 5'd0, 0, 1'b0, 1'b0);
		addCase("jal", iType(opJal, 5'd0, 16'h0040), 0, 0, 5'd31, 0, 1'b1, 1'b0);
	endtask

	task automatic buildRandom();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		regIdx       rd;
		for (int i = 0; i < 16; i++)
		begin
			a  = nextRandom();
			b  = nextRandom();
			r  = nextRandom();
			rd = r[20:16];
			if (r[31])
				addCase("rand xor", rType(fnXor, rd, 5'd0), a, b, rd, a ^ b, 1'b1, 1'b1);
			else
				addCase("rand addu", rType(fnAddu, rd, 5'd0), a, b, rd, a + b, 1'b1, 1'b1);
		end
	endtask

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////
	// Dest and value only matter when the register is written
	task automatic checkRetire(input retirePkt got, input retirePkt exp, input bit chkVal,
		input string name);
		bit ok;
		ok = (got.regWe === exp.regWe);
		if (exp.regWe && got.dest !== exp.dest)
			ok = 1'b0;
		if (exp.regWe && chkVal && got.value !== exp.value)
			ok = 1'b0;
		nChecks++;
		if (!ok)
		begin
			errors++;
			$display("ERROR %0t: %s retired dest=%0d value=%h we=%b, expected dest=%0d value=%h we=%b",
				$time, name, got.dest, got.value, got.regWe, exp.dest, exp.value, exp.regWe);
		end
		$display("%s: %s", name, ok ? "ok" : "mismatch");
	endtask

	task automatic checkCredits(input creditCount got, input creditCount exp, input string what);
		nChecks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
		$display("%s: %s", what, (got === exp) ? "ok" : "mismatch");
	endtask

	initial
	begin
		arstN      = 1'b0;
		issueValid = 1'b0;
		issue      = '0;
		lcgState   = 32'd63;
		credits    = creditCount'(`EXEC_FIFO_DEPTH);
		minCredits = credits;
		nIssued    = 0;
		nRetired   = 0;
		returned   = 0;
		cycles     = 0;
		nChecks    = 0;
		errors     = 0;
		buildTable();
		buildRandom();
		limit = stimPkt.size() * (`EXEC_DIV_CYCLES + 4) + 50;

		repeat (4) @(negedge clk);
		arstN = 1'b1;
		if (retireValid || creditReturn)
		begin
			errors++;
			$display("Retire or credit output was active while coming out of reset");
		end

		while ((nRetired < stimPkt.size() || returned < stimPkt.size()) && cycles < limit)
		begin
			@(negedge clk);
			cycles++;
			if (creditReturn)
			begin
				credits++;
				returned++;
			end
			if (retireValid)
			begin
				if (nRetired >= nIssued)
				begin
					errors++;
					$display("A retire arrived at time %0t with no instruction outstanding", $time);
				end
				else
					checkRetire(retire, expPkt[nRetired], expValChk[nRetired], caseName[nRetired]);
				nRetired++;
			end
			// Issue only while a credit is held
			if (nIssued < stimPkt.size() && credits > 0)
			begin
				issueValid = 1'b1;
				issue      = stimPkt[nIssued];
				credits--;
				nIssued++;
			end
			else
				issueValid = 1'b0;
			if (credits < minCredits)
				minCredits = credits;
		end
		issueValid = 1'b0;

		timedOut = (nRetired < stimPkt.size() || returned < stimPkt.size());
		if (timedOut)
			$display("Timed out after %0d cycles with %0d of %0d instructions retired",
				cycles, nRetired, stimPkt.size());
		checkCredits(minCredits, '0, "lowest credit count");
		checkCredits(credits, creditCount'(`EXEC_FIFO_DEPTH), "credits at end");
		$display("Checks run %0d, passed %0d, failed %0d", nChecks, nChecks - errors, errors);
		if (errors == 0 && !timedOut)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end
endmodule

//--- src/execTop.sv
module execTop (
	input  logic               clk,
	input  logic               arstN,
	input  logic               issueValid,
	input  ctrl_pkg::issuePkt  issue,
	output logic               creditReturn,
	output ctrl_pkg::retirePkt retire,
	output logic               retireValid
);
	import ctrl_pkg::*;

	issuePkt   headPkt;
	ctrlBundle ctrl;
	dataWord   aluResult;
	dataWord   hi;
	dataWord   lo;
	logic      notEmpty;
	logic      pop;
	logic      mduStart;
	logic      mduDone;
	logic      retireStrobe;
	logic      retireSilent;

	instrFifo i_fifo (
		.clk, .arstN,
		.push(issueValid), .pushPkt(issue), .pop,
		.headPkt, .notEmpty, .creditReturn
	);

	mainDecoder i_decoder (
		.instr(headPkt.instr), .ctrl
	);

	issueFsm i_fsm (
		.clk, .arstN,
		.notEmpty, .ctrl, .mduDone,
		.pop, .mduStart, .retireStrobe, .retireSilent
	);

	//////////////////////////////////////////////////
	// Execute units on the queue head
	//////////////////////////////////////////////////
	aluUnit i_alu (
		.ctrl, .rsVal(headPkt.rsVal), .rtVal(headPkt.rtVal),
		.imm(headPkt.instr[15:0]), .shamt(headPkt.instr[10:6]),
		.result(aluResult)
	);

	mduUnit i_mdu (
		.clk, .arstN,
		.start(mduStart), .ctrl, .rsVal(headPkt.rsVal), .rtVal(headPkt.rtVal),
		.done(mduDone), .hi, .lo
	);

	writebackStage i_writeback (
		.clk, .arstN,
		.strobe(retireStrobe), .silent(retireSilent),
		.ctrl, .instr(headPkt.instr), .aluResult, .hi, .lo,
		.retire, .retireValid
	);
endmodule

//--- src/instrFifo.sv
`include "exec_config.svh"

module instrFifo (
	input  logic              clk,
	input  logic              arstN,
	input  logic              push,
	input  ctrl_pkg::issuePkt pushPkt,
	input  logic              pop,
	output ctrl_pkg::issuePkt headPkt,
	output logic              notEmpty,
	output logic              creditReturn
);
	import ctrl_pkg::*;

	localparam int depth = `EXEC_FIFO_DEPTH;
	localparam int ptrW  = $clog2(depth);

	issuePkt         slots [depth];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [ptrW:0]   used;

	function automatic logic [ptrW-1:0] nextPtr(logic [ptrW-1:0] p);
		return (p == ptrW'(depth - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk)
	begin
		if (push)
			slots[wrPtr] <= pushPkt;
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			wrPtr        <= '0;
			rdPtr        <= '0;
			used         <= '0;
			creditReturn <= 1'b0;
		end
		else
		begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			used <= used + (ptrW + 1)'(push) - (ptrW + 1)'(pop);
			// One credit back per freed slot
			creditReturn <= pop;
		end
	end

	assign headPkt  = slots[rdPtr];
	assign notEmpty = (used != '0);
endmodule

//--- src/issueFsm.sv
module issueFsm (
	input  logic                clk,
	input  logic                arstN,
	input  logic                notEmpty,
	input  ctrl_pkg::ctrlBundle ctrl,
	input  logic                mduDone,
	output logic                pop,
	output logic                mduStart,
	output logic                retireStrobe,
	output logic                retireSilent
);
	import ctrl_pkg::*;

	typedef enum logic {stIdle, stMduWait} stateE;

	stateE state;
	stateE stateNext;
	logic  isLong;

	// Multiply and divide hold the issue slot until done
	assign isLong = ctrl.mduOp inside {mduMult, mduMultu, mduDiv, mduDivu};

	always_comb
	begin
		stateNext    = state;
		pop          = 1'b0;
		mduStart     = 1'b0;
		retireStrobe = 1'b0;
		retireSilent = 1'b0;
		case (state)
			stIdle:
			begin
				if (notEmpty)
				begin
					pop      = 1'b1;
					mduStart = ctrl.mduEn;
					if (isLong)
						stateNext = stMduWait;
					else
						retireStrobe = 1'b1;
				end
			end
			stMduWait:
			begin
				if (mduDone)
				begin
					retireStrobe = 1'b1;
					retireSilent = 1'b1;
					stateNext    = stIdle;
				end
			end
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			state <= stIdle;
		else
			state <= stateNext;
	end
endmodule

//--- mdu/mduUnit.sv
`include "exec_config.svh"

module mduUnit (
	input  logic                clk,
	input  logic                arstN,
	input  logic                start,
	input  ctrl_pkg::ctrlBundle ctrl,
	input  ctrl_pkg::dataWord   rsVal,
	input  ctrl_pkg::dataWord   rtVal,
	output logic                done,
	output ctrl_pkg::dataWord   hi,
	output ctrl_pkg::dataWord   lo
);
	import ctrl_pkg::*;

	mduOpE                     opReg;
	dataWord                   opA;
	dataWord                   opB;
	dataWord                   quot;
	dataWord                   rem;
	logic [2*`EXEC_DATA_W-1:0] prodS;
	logic [2*`EXEC_DATA_W-1:0] prodU;
	logic                      isMul;
	logic                      isDiv;
	logic [3:0]                latency;

	assign isMul   = ctrl.mduOp inside {mduMult, mduMultu};
	assign isDiv   = ctrl.mduOp inside {mduDiv, mduDivu};
	assign latency = isDiv ? 4'(`EXEC_DIV_CYCLES) : 4'(`EXEC_MULT_CYCLES);

	mduTimer i_timer (
		.clk, .arstN,
		.load(start && (isMul || isDiv)), .count(latency), .expired(done)
	);

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			opA <= rsVal;
			opB <= rtVal;
		end
	end

	//////////////////////////////////////////////////
	// Results from the held operands
	//////////////////////////////////////////////////
	assign prodS = $signed(opA) * $signed(opB);
	assign prodU = opA * opB;

	always_comb
	begin
		if (opB == '0)
		begin
			// Divide by zero keeps the dividend in HI
			quot = '1;
			rem  = opA;
		end
		else if (opReg == mduDiv)
		begin
			quot = $signed(opA) / $signed(opB);
			rem  = $signed(opA) % $signed(opB);
		end
		else
		begin
			quot = opA / opB;
			rem  = opA % opB;
		end
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			opReg <= mduNone;
			hi    <= '0;
			lo    <= '0;
		end
		else if (start)
		begin
			opReg <= ctrl.mduOp;
			if (ctrl.mduOp == mduMthi)
				hi <= rsVal;
			if (ctrl.mduOp == mduMtlo)
				lo <= rsVal;
		end
		else if (done)
		begin
			case (opReg)
				mduMult:  {hi, lo} <= prodS;
				mduMultu: {hi, lo} <= prodU;
				mduDiv, mduDivu:
				begin
					hi <= rem;
					lo <= quot;
				end
				default: ;
			endcase
		end
	end
endmodule

//--- mdu/mduTimer.sv
module mduTimer (
	input  logic       clk,
	input  logic       arstN,
	input  logic       load,
	input  logic [3:0] count,
	output logic       expired
);
	logic [3:0] remaining;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			remaining <= '0;
		else if (load)
			remaining <= count;
		else if (remaining != '0)
			remaining <= remaining - 4'd1;
	end

	// Last busy cycle of the operation
	assign expired = (remaining == 4'd1);
endmodule

//--- src/writebackStage.sv
module writebackStage (
	input  logic                clk,
	input  logic                arstN,
	input  logic                strobe,
	input  logic                silent,
	input  ctrl_pkg::ctrlBundle ctrl,
	input  isa_pkg::instrWord   instr,
	input  ctrl_pkg::dataWord   aluResult,
	input  ctrl_pkg::dataWord   hi,
	input  ctrl_pkg::dataWord   lo,
	output ctrl_pkg::retirePkt  retire,
	output logic                retireValid
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	regIdx   dest;
	dataWord value;
	logic    writeEn;

	always_comb
	begin
		case (ctrl.destSel)
			destRd:  dest = instr[15:11];
			destRt:  dest = instr[20:16];
			destRa:  dest = 5'd31;
			default: dest = '0;
		endcase
	end

	always_comb
	begin
		case (ctrl.resultSel)
			resAlu:  value = aluResult;
			resHi:   value = hi;
			resLo:   value = lo;
			// No PC reaches this stage so the link value reads as zero
			resLink: value = '0;
		endcase
	end

	// Loads and COP0 moves have no data source here
	assign writeEn = ctrl.regWe && !silent && !ctrl.dataWbSel
		&& (opcodeE'(instr[31:26]) != opCop0);

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			retire      <= '0;
			retireValid <= 1'b0;
		end
		else
		begin
			retireValid <= strobe;
			if (strobe)
			begin
				retire.dest  <= silent ? '0 : dest;
				retire.value <= silent ? '0 : value;
				retire.regWe <= writeEn;
			end
		end
	end
endmodule

//--- src/aluUnit.sv
module aluUnit (
	input  ctrl_pkg::ctrlBundle ctrl,
	input  ctrl_pkg::dataWord   rsVal,
	input  ctrl_pkg::dataWord   rtVal,
	input  logic [15:0]         imm,
	input  logic [4:0]          shamt,
	output ctrl_pkg::dataWord   result
);
	import ctrl_pkg::*;

	dataWord extImm;
	dataWord opB;

	always_comb
	begin
		case (ctrl.extCtrl)
			extSign:  extImm = {{16{imm[15]}}, imm};
			extUpper: extImm = {imm, 16'b0};
			default:  extImm = {16'b0, imm};
		endcase
	end

	assign opB = ctrl.aluBSel ? extImm : rtVal;

	// Shifts always act on rt
	always_comb
	begin
		case (ctrl.aluOp)
			aluAdd:  result = rsVal + opB;
			aluSub:  result = rsVal - opB;
			aluAnd:  result = rsVal & opB;
			aluOr:   result = rsVal | opB;
			aluXor:  result = rsVal ^ opB;
			aluNor:  result = ~(rsVal | opB);
			aluSlt:  result = dataWord'($signed(rsVal) < $signed(opB));
			aluSltu: result = dataWord'(rsVal < opB);
			aluSll:  result = rtVal << shamt;
			aluSrl:  result = rtVal >> shamt;
			aluSra:  result = $signed(rtVal) >>> shamt;
			aluSllv: result = rtVal << rsVal[4:0];
			aluSrlv: result = rtVal >> rsVal[4:0];
			aluSrav: result = $signed(rtVal) >>> rsVal[4:0];
			aluLui:  result = extImm;
			default: result = '0;
		endcase
	end
endmodule

//--- decode/mainDecoder.sv
module mainDecoder (
	input  isa_pkg::instrWord   instr,
	output ctrl_pkg::ctrlBundle ctrl
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	opcodeField opcode;
	functField  funct;
	regIdx      rs;
	regIdx      rt;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];

	// I-type op writing rt with an immediate operand B
	function automatic ctrlBundle immOp(aluOpE op, logic [1:0] ext);
		ctrlBundle c;
		c = '0;
		c.regWe   = 1'b1;
		c.destSel = destRt;
		c.aluBSel = 1'b1;
		c.extCtrl = ext;
		c.aluOp   = op;
		return c;
	endfunction

	always_comb
	begin
		ctrl = '0;
		case (opcodeE'(opcode))
			opSpecial:
			begin
				ctrl.regWe = 1'b1;
				case (functE'(funct))
					fnAdd, fnAddu: ctrl.aluOp = aluAdd;
					fnSub, fnSubu: ctrl.aluOp = aluSub;
					fnAnd:   ctrl.aluOp = aluAnd;
					fnOr:    ctrl.aluOp = aluOr;
					fnXor:   ctrl.aluOp = aluXor;
					fnNor:   ctrl.aluOp = aluNor;
					fnSlt:   ctrl.aluOp = aluSlt;
					fnSltu:  ctrl.aluOp = aluSltu;
					fnSll:   ctrl.aluOp = aluSll;
					fnSrl:   ctrl.aluOp = aluSrl;
					fnSra:   ctrl.aluOp = aluSra;
					fnSllv:  ctrl.aluOp = aluSllv;
					fnSrlv:  ctrl.aluOp = aluSrlv;
					fnSrav:  ctrl.aluOp = aluSrav;
					fnMfhi:  ctrl.resultSel = resHi;
					fnMflo:  ctrl.resultSel = resLo;
					fnMult:  ctrl.mduOp = mduMult;
					fnMultu: ctrl.mduOp = mduMultu;
					fnDiv:   ctrl.mduOp = mduDiv;
					fnDivu:  ctrl.mduOp = mduDivu;
					fnMthi:  ctrl.mduOp = mduMthi;
					fnMtlo:  ctrl.mduOp = mduMtlo;
					fnJr:
					begin
						ctrl.regWe = 1'b0;
						ctrl.jump  = 1'b1;
					end
					fnJalr:
					begin
						ctrl.jump      = 1'b1;
						ctrl.resultSel = resLink;
					end
					default: ctrl = '0;
				endcase
				// MDU ops never write a GPR
				ctrl.mduEn = (ctrl.mduOp != mduNone);
				if (ctrl.mduEn)
					ctrl.regWe = 1'b0;
			end
			opAddi, opAddiu: ctrl = immOp(aluAdd, extSign);
			opSlti:  ctrl = immOp(aluSlt, extSign);
			opSltiu: ctrl = immOp(aluSltu, extSign);
			opAndi:  ctrl = immOp(aluAnd, extZero);
			opOri:   ctrl = immOp(aluOr, extZero);
			opXori:  ctrl = immOp(aluXor, extZero);
			opLui:   ctrl = immOp(aluLui, extUpper);
			opLb, opLbu, opLh, opLhu, opLw:
			begin
				ctrl = immOp(aluAdd, extSign);
				ctrl.dataWbSel = 1'b1;
			end
			opSb, opSh, opSw:
			begin
				ctrl.aluBSel = 1'b1;
				ctrl.extCtrl = extSign;
				ctrl.dmWe    = 1'b1;
			end
			opBeq, opBne, opBlez, opBgtz: ctrl.isBr = 1'b1;
			opRegimm: ctrl.isBr = (regimmE'(rt) inside {rtBltz, rtBgez});
			opJ:
			begin
				ctrl.jump  = 1'b1;
				ctrl.jType = 1'b1;
			end
			opJal:
			begin
				ctrl.jump      = 1'b1;
				ctrl.jType     = 1'b1;
				ctrl.destSel   = destRa;
				ctrl.resultSel = resLink;
				ctrl.regWe     = 1'b1;
			end
			opCop0:
			begin
				ctrl.destSel = destRt;
				ctrl.regWe   = (rs == rsMfc0);
			end
			default: ctrl = '0;
		endcase

		//////////////////////////////////////////////////
		// Access width for loads and stores
		//////////////////////////////////////////////////
		case (opcodeE'(opcode))
			opLb, opSb: ctrl.slCtrl = slByte;
			opLbu:      ctrl.slCtrl = slByteU;
			opLh, opSh: ctrl.slCtrl = slHalf;
			opLhu:      ctrl.slCtrl = slHalfU;
			opLw, opSw: ctrl.slCtrl = slWord;
			default: ;
		endcase
	end
endmodule

//--- common/ctrl_pkg.sv
`include "exec_config.svh"

package ctrl_pkg;
	import isa_pkg::*;

	typedef logic [`EXEC_DATA_W-1:0] dataWord;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor, aluSlt, aluSltu,
		aluSll, aluSrl, aluSra, aluSllv, aluSrlv, aluSrav, aluLui
	} aluOpE;

	typedef enum logic [2:0] {
		mduNone, mduMult, mduMultu, mduDiv, mduDivu, mduMthi, mduMtlo
	} mduOpE;

	typedef enum logic [1:0] {resAlu, resHi, resLo, resLink} resultSelE;

	// Destination register select
	localparam logic [1:0] destRd = 2'd0;
	localparam logic [1:0] destRt = 2'd1;
	localparam logic [1:0] destRa = 2'd2;

	// Immediate extension
	localparam logic [1:0] extZero  = 2'd0;
	localparam logic [1:0] extSign  = 2'd1;
	localparam logic [1:0] extUpper = 2'd2;

	// Load/store access width
	localparam logic [2:0] slByte  = 3'd1;
	localparam logic [2:0] slByteU = 3'd2;
	localparam logic [2:0] slHalf  = 3'd3;
	localparam logic [2:0] slHalfU = 3'd4;
	localparam logic [2:0] slWord  = 3'd5;

	typedef struct packed {
		logic       isBr;
		logic       jump;
		logic       jType;
		logic [1:0] destSel;
		logic       aluBSel;
		resultSelE  resultSel;
		logic       mduEn;
		logic       dmWe;
		logic       dataWbSel;
		logic       regWe;
		logic [1:0] extCtrl;
		aluOpE      aluOp;
		logic [2:0] slCtrl;
		mduOpE      mduOp;
	} ctrlBundle;

	typedef struct packed {
		instrWord instr;
		dataWord  rsVal;
		dataWord  rtVal;
	} issuePkt;

	typedef struct packed {
		regIdx   dest;
		dataWord value;
		logic    regWe;
	} retirePkt;
endpackage

//--- common/isa_pkg.sv
package isa_pkg;
	typedef logic [4:0]  regIdx;
	typedef logic [5:0]  opcodeField;
	typedef logic [5:0]  functField;
	typedef logic [31:0] instrWord;

	// Primary opcodes, bits 31:26
	typedef enum opcodeField {
		opSpecial = 6'h00, opRegimm = 6'h01, opJ = 6'h02, opJal = 6'h03,
		opBeq = 6'h04, opBne = 6'h05, opBlez = 6'h06, opBgtz = 6'h07,
		opAddi = 6'h08, opAddiu = 6'h09, opSlti = 6'h0a, opSltiu = 6'h0b,
		opAndi = 6'h0c, opOri = 6'h0d, opXori = 6'h0e, opLui = 6'h0f,
		opCop0 = 6'h10, opLb = 6'h20, opLh = 6'h21, opLw = 6'h23,
		opLbu = 6'h24, opLhu = 6'h25, opSb = 6'h28, opSh = 6'h29, opSw = 6'h2b
	} opcodeE;

	// SPECIAL funct codes, bits 5:0
	typedef enum functField {
		fnSll = 6'h00, fnSrl = 6'h02, fnSra = 6'h03, fnSllv = 6'h04,
		fnSrlv = 6'h06, fnSrav = 6'h07, fnJr = 6'h08, fnJalr = 6'h09,
		fnMfhi = 6'h10, fnMthi = 6'h11, fnMflo = 6'h12, fnMtlo = 6'h13,
		fnMult = 6'h18, fnMultu = 6'h19, fnDiv = 6'h1a, fnDivu = 6'h1b,
		fnAdd = 6'h20, fnAddu = 6'h21, fnSub = 6'h22, fnSubu = 6'h23,
		fnAnd = 6'h24, fnOr = 6'h25, fnXor = 6'h26, fnNor = 6'h27,
		fnSlt = 6'h2a, fnSltu = 6'h2b
	} functE;

	// REGIMM branch selects in the rt field
	typedef enum regIdx {rtBltz = 5'h00, rtBgez = 5'h01} regimmE;

	// COP0 move-from in the rs field
	localparam regIdx rsMfc0 = 5'b00000;
endpackage

//--- common/exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Operand width
`define EXEC_DATA_W 32

// Issue queue entries, also the credit count after reset
`define EXEC_FIFO_DEPTH 4

// Multiply/divide latency in cycles
`define EXEC_MULT_CYCLES 4
`define EXEC_DIV_CYCLES 8

`endif
